/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [6:0]      opcode_t;

  // major opcodes, bits 6:0 of the instruction word
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_system = 7'b1110011;
  localparam opcode_t op_fence  = 7'b0001111;

  // funct7 that selects sub and the arithmetic shifts
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef enum logic [5:0] {
    kind_invalid,
    kind_lui, kind_auipc, kind_jal, kind_jalr,
    kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu, kind_bgeu,
    kind_addi, kind_slti, kind_sltiu, kind_xori, kind_ori, kind_andi,
    kind_slli, kind_srli, kind_srai,
    kind_add, kind_sub, kind_sll, kind_slt, kind_sltu,
    kind_xor, kind_srl, kind_sra, kind_or, kind_and,
    kind_ecall, kind_fence
  } insn_kind_e;

endpackage

/* hw/pipe_pkg.sv */
package pipe_pkg;

  // status of whatever sits in writeback, one bit per case
  typedef enum logic [7:0] {
    cycle_reset        = 8'd1,
    cycle_no_stall     = 8'd2,
    cycle_taken_branch = 8'd4
  } cycle_status_e;

  typedef struct packed {
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t insn;
    cycle_status_e     status;
  } decode_stage_t;

  typedef struct packed {
    rv_isa_pkg::word_t      pc;
    rv_isa_pkg::word_t      insn;
    cycle_status_e          status;
    rv_isa_pkg::reg_idx_t   rs1;
    rv_isa_pkg::reg_idx_t   rs2;
    rv_isa_pkg::reg_idx_t   rd;
    rv_isa_pkg::insn_kind_e kind;
    rv_isa_pkg::word_t      imm_i;
    rv_isa_pkg::word_t      imm_b;
    rv_isa_pkg::word_t      imm_j;
    rv_isa_pkg::word_t      imm_u;
  } execute_stage_t;

  // execute output, also the memory and writeback stage contents
  typedef struct packed {
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::word_t    insn;
    cycle_status_e        status;
    logic                 we;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    data;
    logic                 halt;
  } result_t;

  typedef struct packed {
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::word_t    insn;
    cycle_status_e        status;
    logic                 we;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    data;
  } trace_t;

endpackage

/* hw/insn_decoder.sv */
`timescale 1ns/10ps

module insn_decoder (
  input  rv_isa_pkg::word_t      insn_i,
  output rv_isa_pkg::insn_kind_e kind_o,
  output rv_isa_pkg::reg_idx_t   rs1_o,
  output rv_isa_pkg::reg_idx_t   rs2_o,
  output rv_isa_pkg::reg_idx_t   rd_o,
  output rv_isa_pkg::word_t      imm_i_o,
  output rv_isa_pkg::word_t      imm_b_o,
  output rv_isa_pkg::word_t      imm_j_o,
  output rv_isa_pkg::word_t      imm_u_o
);

  rv_isa_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  assign rd_o  = insn_i[11:7];
  assign rs1_o = insn_i[19:15];
  assign rs2_o = insn_i[24:20];

  // immediates, all sign-extended from bit 31
  assign imm_i_o = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_b_o = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_j_o = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21],
                    1'b0};
  assign imm_u_o = {insn_i[31:12], 12'b0};

  always_comb begin
    kind_o = rv_isa_pkg::kind_invalid;
    case (opcode)
      rv_isa_pkg::op_lui:   kind_o = rv_isa_pkg::kind_lui;
      rv_isa_pkg::op_auipc: kind_o = rv_isa_pkg::kind_auipc;
      rv_isa_pkg::op_jal:   kind_o = rv_isa_pkg::kind_jal;
      rv_isa_pkg::op_jalr:  kind_o = rv_isa_pkg::kind_jalr;
      rv_isa_pkg::op_fence: kind_o = rv_isa_pkg::kind_fence;
      rv_isa_pkg::op_branch: begin
        case (funct3)
          3'b000:  kind_o = rv_isa_pkg::kind_beq;
          3'b001:  kind_o = rv_isa_pkg::kind_bne;
          3'b100:  kind_o = rv_isa_pkg::kind_blt;
          3'b101:  kind_o = rv_isa_pkg::kind_bge;
          3'b110:  kind_o = rv_isa_pkg::kind_bltu;
          3'b111:  kind_o = rv_isa_pkg::kind_bgeu;
          default: kind_o = rv_isa_pkg::kind_invalid;
        endcase
      end
      rv_isa_pkg::op_imm: begin
        case (funct3)
          3'b000: kind_o = rv_isa_pkg::kind_addi;
          3'b010: kind_o = rv_isa_pkg::kind_slti;
          3'b011: kind_o = rv_isa_pkg::kind_sltiu;
          3'b100: kind_o = rv_isa_pkg::kind_xori;
          3'b110: kind_o = rv_isa_pkg::kind_ori;
          3'b111: kind_o = rv_isa_pkg::kind_andi;
          // shifts need a clean funct7
          3'b001: if (funct7 == 7'd0) kind_o = rv_isa_pkg::kind_slli;
          default: begin
            if (funct7 == 7'd0) kind_o = rv_isa_pkg::kind_srli;
            else if (funct7 == rv_isa_pkg::funct7_alt) kind_o = rv_isa_pkg::kind_srai;
          end
        endcase
      end
      rv_isa_pkg::op_reg: begin
        if (funct7 == rv_isa_pkg::funct7_alt) begin
          if (funct3 == 3'b000) kind_o = rv_isa_pkg::kind_sub;
          else if (funct3 == 3'b101) kind_o = rv_isa_pkg::kind_sra;
        end else if (funct7 == 7'd0) begin
          case (funct3)
            3'b000:  kind_o = rv_isa_pkg::kind_add;
            3'b001:  kind_o = rv_isa_pkg::kind_sll;
            3'b010:  kind_o = rv_isa_pkg::kind_slt;
            3'b011:  kind_o = rv_isa_pkg::kind_sltu;
            3'b100:  kind_o = rv_isa_pkg::kind_xor;
            3'b101:  kind_o = rv_isa_pkg::kind_srl;
            3'b110:  kind_o = rv_isa_pkg::kind_or;
            default: kind_o = rv_isa_pkg::kind_and;
          endcase
        end
      end
      rv_isa_pkg::op_system: begin
        // only a plain ecall is recognised
        if (insn_i[31:7] == 25'd0) kind_o = rv_isa_pkg::kind_ecall;
      end
      default: kind_o = rv_isa_pkg::kind_invalid;
    endcase
  end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we_i,
  input  rv_isa_pkg::reg_idx_t wr_idx_i,
  input  rv_isa_pkg::word_t    wr_data_i,
  input  rv_isa_pkg::reg_idx_t rs1_idx_i,
  input  rv_isa_pkg::reg_idx_t rs2_idx_i,
  output rv_isa_pkg::word_t    rs1_data_o,
  output rv_isa_pkg::word_t    rs2_data_o
);

  // x0 has no storage
  rv_isa_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wr_idx_i != '0) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  // same-cycle write shows up on the read ports
  always_comb begin
    if (rs1_idx_i == '0) rs1_data_o = '0;
    else if (we_i && wr_idx_i == rs1_idx_i) rs1_data_o = wr_data_i;
    else rs1_data_o = regs[rs1_idx_i];
  end

  always_comb begin
    if (rs2_idx_i == '0) rs2_data_o = '0;
    else if (we_i && wr_idx_i == rs2_idx_i) rs2_data_o = wr_data_i;
    else rs2_data_o = regs[rs2_idx_i];
  end

endmodule

/* hw/stage_reg.sv */
`timescale 1ns/10ps

module stage_reg #(
  parameter type      payload_t = logic [31:0],
  parameter payload_t reset_val = '0,
  parameter payload_t flush_val = '0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     flush_i,
  input  payload_t d_i,
  output payload_t q_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      q_o <= reset_val;
    end else if (flush_i) begin
      // squashed slot becomes a bubble
      q_o <= flush_val;
    end else begin
      q_o <= d_i;
    end
  end

  // redirect from execute must be resolved every cycle
  flush_known_a: assert property (@(posedge clk) disable iff (rst) !$isunknown(flush_i));

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/10ps

module execute_unit (
  input  pipe_pkg::execute_stage_t ex_i,
  input  pipe_pkg::result_t        mem_fwd_i,
  input  pipe_pkg::result_t        wb_fwd_i,
  input  rv_isa_pkg::word_t        rs1_rf_i,
  input  rv_isa_pkg::word_t        rs2_rf_i,
  output pipe_pkg::result_t        result_o,
  output logic                     redirect_o,
  output rv_isa_pkg::word_t        target_o
);

  rv_isa_pkg::word_t rs1_val;
  rv_isa_pkg::word_t rs2_val;
  rv_isa_pkg::word_t alu_out;
  rv_isa_pkg::word_t link_addr;
  rv_isa_pkg::word_t branch_addr;
  logic              wr_en;
  logic              halt;

  // nearest producer wins, x0 never forwards
  function automatic rv_isa_pkg::word_t pick_operand(
    input rv_isa_pkg::reg_idx_t idx,
    input rv_isa_pkg::word_t    rf_val,
    input pipe_pkg::result_t    mem_r,
    input pipe_pkg::result_t    wb_r
  );
    rv_isa_pkg::word_t val;
    val = rf_val;
    if (idx != '0) begin
      if (mem_r.we && mem_r.rd == idx) val = mem_r.data;
      else if (wb_r.we && wb_r.rd == idx) val = wb_r.data;
    end
    return val;
  endfunction

  assign rs1_val = pick_operand(ex_i.rs1, rs1_rf_i, mem_fwd_i, wb_fwd_i);
  assign rs2_val = pick_operand(ex_i.rs2, rs2_rf_i, mem_fwd_i, wb_fwd_i);

  assign link_addr   = ex_i.pc + 32'd4;
  assign branch_addr = ex_i.pc + ex_i.imm_b;

  // branch and jump resolution
  always_comb begin
    redirect_o = 1'b0;
    target_o   = branch_addr;
    case (ex_i.kind)
      rv_isa_pkg::kind_beq:  redirect_o = (rs1_val == rs2_val);
      rv_isa_pkg::kind_bne:  redirect_o = (rs1_val != rs2_val);
      rv_isa_pkg::kind_blt:  redirect_o = ($signed(rs1_val) < $signed(rs2_val));
      rv_isa_pkg::kind_bge:  redirect_o = ($signed(rs1_val) >= $signed(rs2_val));
      rv_isa_pkg::kind_bltu: redirect_o = (rs1_val < rs2_val);
      rv_isa_pkg::kind_bgeu: redirect_o = (rs1_val >= rs2_val);
      rv_isa_pkg::kind_jal: begin
        redirect_o = 1'b1;
        target_o   = ex_i.pc + ex_i.imm_j;
      end
      rv_isa_pkg::kind_jalr: begin
        redirect_o = 1'b1;
        target_o   = (rs1_val + ex_i.imm_i) & ~32'd1;
      end
      default: redirect_o = 1'b0;
    endcase
  end

  always_comb begin
    alu_out = '0;
    wr_en   = 1'b1;
    halt    = 1'b0;
    case (ex_i.kind)
      rv_isa_pkg::kind_lui:   alu_out = ex_i.imm_u;
      rv_isa_pkg::kind_auipc: alu_out = ex_i.pc + ex_i.imm_u;
      rv_isa_pkg::kind_jal:   alu_out = link_addr;
      rv_isa_pkg::kind_jalr:  alu_out = link_addr;
      rv_isa_pkg::kind_addi:  alu_out = rs1_val + ex_i.imm_i;
      rv_isa_pkg::kind_slti:  alu_out = {31'b0, $signed(rs1_val) < $signed(ex_i.imm_i)};
      rv_isa_pkg::kind_sltiu: alu_out = {31'b0, rs1_val < ex_i.imm_i};
      rv_isa_pkg::kind_xori:  alu_out = rs1_val ^ ex_i.imm_i;
      rv_isa_pkg::kind_ori:   alu_out = rs1_val | ex_i.imm_i;
      rv_isa_pkg::kind_andi:  alu_out = rs1_val & ex_i.imm_i;
      rv_isa_pkg::kind_slli:  alu_out = rs1_val << ex_i.imm_i[4:0];
      rv_isa_pkg::kind_srli:  alu_out = rs1_val >> ex_i.imm_i[4:0];
      rv_isa_pkg::kind_srai:  alu_out = $signed(rs1_val) >>> ex_i.imm_i[4:0];
      rv_isa_pkg::kind_add:   alu_out = rs1_val + rs2_val;
      rv_isa_pkg::kind_sub:   alu_out = rs1_val - rs2_val;
      rv_isa_pkg::kind_sll:   alu_out = rs1_val << rs2_val[4:0];
      rv_isa_pkg::kind_slt:   alu_out = {31'b0, $signed(rs1_val) < $signed(rs2_val)};
      rv_isa_pkg::kind_sltu:  alu_out = {31'b0, rs1_val < rs2_val};
      rv_isa_pkg::kind_xor:   alu_out = rs1_val ^ rs2_val;
      rv_isa_pkg::kind_srl:   alu_out = rs1_val >> rs2_val[4:0];
      rv_isa_pkg::kind_sra:   alu_out = $signed(rs1_val) >>> rs2_val[4:0];
      rv_isa_pkg::kind_or:    alu_out = rs1_val | rs2_val;
      rv_isa_pkg::kind_and:   alu_out = rs1_val & rs2_val;
      rv_isa_pkg::kind_ecall: begin
        wr_en = 1'b0;
        halt  = 1'b1;
      end
      // branches, fence, bubbles and unknown encodings write nothing
      default: wr_en = 1'b0;
    endcase
  end

  assign result_o = '{pc: ex_i.pc, insn: ex_i.insn, status: ex_i.status, we: wr_en,
                      rd: ex_i.rd, data: alu_out, halt: halt};

  // a misaligned jalr base or branch offset would break fetch alignment
  always_comb begin
    if (redirect_o) begin
      assert (target_o[1:0] == 2'b00)
        else $error("execute_unit: misaligned redirect target %h", target_o);
    end
  end

endmodule

/* hw/rv_pipeline.sv */
`timescale 1ns/10ps

module rv_pipeline #(
  parameter rv_isa_pkg::word_t reset_pc = '0
) (
  input  logic              clk,
  input  logic              rst,
  output rv_isa_pkg::word_t pc_o,
  input  rv_isa_pkg::word_t insn_i,
  output pipe_pkg::trace_t  trace_o,
  output logic              halt_o
);

  localparam pipe_pkg::decode_stage_t dec_reset_c = '{status: pipe_pkg::cycle_reset,
                                                      default: '0};
  localparam pipe_pkg::decode_stage_t dec_flush_c = '{status: pipe_pkg::cycle_taken_branch,
                                                      default: '0};
  localparam pipe_pkg::execute_stage_t ex_reset_c = '{status: pipe_pkg::cycle_reset,
                                                      kind: rv_isa_pkg::kind_invalid,
                                                      default: '0};
  localparam pipe_pkg::execute_stage_t ex_flush_c = '{status: pipe_pkg::cycle_taken_branch,
                                                      kind: rv_isa_pkg::kind_invalid,
                                                      default: '0};
  localparam pipe_pkg::result_t res_reset_c = '{status: pipe_pkg::cycle_reset, default: '0};

  rv_isa_pkg::word_t        pc_q;
  pipe_pkg::decode_stage_t  dec_d, dec_q;
  pipe_pkg::execute_stage_t ex_d, ex_q;
  pipe_pkg::result_t        ex_result, mem_q, wb_q;
  rv_isa_pkg::insn_kind_e   dec_kind;
  rv_isa_pkg::reg_idx_t     dec_rs1, dec_rs2, dec_rd;
  rv_isa_pkg::word_t        dec_imm_i, dec_imm_b, dec_imm_j, dec_imm_u;
  rv_isa_pkg::word_t        rs1_rf, rs2_rf, target;
  logic                     redirect;

  // fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= reset_pc;
    end else if (redirect) begin
      pc_q <= target;
    end else begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign pc_o  = pc_q;
  assign dec_d = '{pc: pc_q, insn: insn_i, status: pipe_pkg::cycle_no_stall};

  stage_reg #(
    .payload_t(pipe_pkg::decode_stage_t),
    .reset_val(dec_reset_c),
    .flush_val(dec_flush_c)
  ) u_dec_reg (
    .clk(clk), .rst(rst), .flush_i(redirect), .d_i(dec_d), .q_o(dec_q)
  );

  insn_decoder u_decoder (
    .insn_i(dec_q.insn), .kind_o(dec_kind),
    .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
    .imm_i_o(dec_imm_i), .imm_b_o(dec_imm_b), .imm_j_o(dec_imm_j), .imm_u_o(dec_imm_u)
  );

  assign ex_d = '{pc: dec_q.pc, insn: dec_q.insn, status: dec_q.status,
                  rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd, kind: dec_kind,
                  imm_i: dec_imm_i, imm_b: dec_imm_b, imm_j: dec_imm_j, imm_u: dec_imm_u};

  stage_reg #(
    .payload_t(pipe_pkg::execute_stage_t),
    .reset_val(ex_reset_c),
    .flush_val(ex_flush_c)
  ) u_ex_reg (
    .clk(clk), .rst(rst), .flush_i(redirect), .d_i(ex_d), .q_o(ex_q)
  );

  // operands are read in execute, written back from wb
  reg_file u_reg_file (
    .clk(clk), .rst(rst),
    .we_i(wb_q.we), .wr_idx_i(wb_q.rd), .wr_data_i(wb_q.data),
    .rs1_idx_i(ex_q.rs1), .rs2_idx_i(ex_q.rs2),
    .rs1_data_o(rs1_rf), .rs2_data_o(rs2_rf)
  );

  execute_unit u_execute (
    .ex_i(ex_q), .mem_fwd_i(mem_q), .wb_fwd_i(wb_q),
    .rs1_rf_i(rs1_rf), .rs2_rf_i(rs2_rf),
    .result_o(ex_result), .redirect_o(redirect), .target_o(target)
  );

  // memory and writeback stages, the taken jump itself keeps its link write
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_q <= res_reset_c;
      wb_q  <= res_reset_c;
    end else begin
      mem_q <= ex_result;
      wb_q  <= mem_q;
    end
  end

  assign trace_o = '{pc: wb_q.pc, insn: wb_q.insn, status: wb_q.status,
                     we: wb_q.we, rd: wb_q.rd, data: wb_q.data};
  assign halt_o  = wb_q.halt;

endmodule

/* bench/wb_checker.sv */
`timescale 1ns/10ps

module wb_checker (
  input  logic             clk,
  input  logic             rst,
  input  pipe_pkg::trace_t trace_i,
  input  logic             halt_i,
  input  logic [31:0]      program_i [0:63],
  output logic             done_o,
  output int               error_count_o,
  output int               check_count_o,
  output int               retire_count_o
);

  typedef struct packed {
    logic [31:0] pc;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [1:0]  gap;
    logic        halt;
  } expect_row_t;

  expect_row_t rows [$];
  expect_row_t row;
  int          reset_cycles;
  int          bubble_cycles;
  logic        overrun;

  task automatic add_row(input int pc, input int we, input int rd, input int data,
                         input int gap, input int halt);
    expect_row_t r;
    r.pc   = pc;
    r.we   = we[0];
    r.rd   = rd[4:0];
    r.data = data;
    r.gap  = gap[1:0];
    r.halt = halt[0];
    rows.push_back(r);
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    check_count_o++;
    if (got !== expected) begin
      error_count_o++;
      $display("Mismatch %s at retirement %0d: got %h, expected %h", name, retire_count_o,
               got, expected);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count_o++;
    $display("%0t: %s", $time, msg);
  endtask

  // columns: pc, we, rd, data, taken_branch cycles just before it, halt
  initial begin
    add_row('h00, 1, 1, 'h1234_5000, 0, 0);
    add_row('h04, 1, 1, 'h1234_5678, 0, 0);
    add_row('h08, 1, 2, 'h0000_1008, 0, 0);
    add_row('h0c, 1, 3, 'hffff_fffb, 0, 0);
    add_row('h10, 1, 4, 'h1234_567d, 0, 0);
    add_row('h14, 1, 5, 'hffff_fffd, 0, 0);
    add_row('h18, 1, 6, 'h0000_0001, 0, 0);
    add_row('h1c, 1, 7, 'h0000_0000, 0, 0);
    add_row('h20, 1, 0, 'h0000_0007, 0, 0);
    add_row('h24, 1, 8, 'h1234_567d, 0, 0);
    add_row('h28, 1, 9, 'hffff_fffd, 0, 0);
    add_row('h2c, 1, 10, 'h7fff_fffd, 0, 0);
    add_row('h30, 1, 11, 'h2468_acf0, 0, 0);
    add_row('h34, 1, 12, 'h1234_4670, 0, 0);
    add_row('h38, 1, 13, 'hffff_fffb, 0, 0);
    add_row('h3c, 1, 14, 'h1234_5679, 0, 0);
    add_row('h40, 1, 15, 'h0000_0001, 0, 0);
    add_row('h44, 1, 16, 'h0000_0000, 0, 0);
    add_row('h48, 1, 17, 'hedcb_a987, 0, 0);
    add_row('h4c, 1, 18, 'h0000_10f8, 0, 0);
    add_row('h50, 1, 19, 'h0000_0078, 0, 0);
    add_row('h54, 1, 20, 'h8000_0000, 0, 0);
    add_row('h58, 1, 21, 'h0800_0000, 0, 0);
    add_row('h5c, 1, 22, 'hf800_0000, 0, 0);
    add_row('h60, 0, 0, 0, 0, 0);
    add_row('h64, 1, 23, 'h0000_0001, 0, 0);
    add_row('h68, 0, 0, 0, 0, 0);
    add_row('h70, 0, 0, 0, 2, 0);
    add_row('h74, 1, 24, 'h0000_0078, 0, 0);
    add_row('h80, 1, 25, 'h0000_0084, 2, 0);
    add_row('h88, 0, 0, 0, 2, 0);
    add_row('h90, 0, 0, 0, 2, 0);
    add_row('h98, 0, 0, 0, 2, 0);
    add_row('ha0, 0, 0, 0, 2, 0);
    add_row('ha4, 0, 0, 0, 0, 1);
  end

  task automatic check_retirement();
    if (retire_count_o >= rows.size()) begin
      if (!overrun) begin
        report_failure("an instruction retired after the last expected one");
      end
      overrun = 1'b1;
    end else begin
      row = rows[retire_count_o];
      // the first retirement ends the reset bubbles
      if (retire_count_o == 0) begin
        compare_field("writeback reset cycles", reset_cycles, 32'd4);
      end
      compare_field("trace_o.pc", trace_i.pc, row.pc);
      compare_field("trace_o.insn", trace_i.insn, program_i[row.pc[7:2]]);
      compare_field("trace_o.we", 32'(trace_i.we), 32'(row.we));
      if (row.we) begin
        compare_field("trace_o.rd", 32'(trace_i.rd), 32'(row.rd));
        compare_field("trace_o.data", trace_i.data, row.data);
      end
      compare_field("halt_o", 32'(halt_i), 32'(row.halt));
      compare_field("taken_branch cycles", bubble_cycles, 32'(row.gap));
      bubble_cycles = 0;
      retire_count_o++;
      done_o = row.halt;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      done_o         = 1'b0;
      error_count_o  = 0;
      check_count_o  = 0;
      retire_count_o = 0;
      reset_cycles   = 0;
      bubble_cycles  = 0;
      overrun        = 1'b0;
    end else if (!done_o) begin
      case (trace_i.status)
        pipe_pkg::cycle_reset: begin
          if (retire_count_o != 0) begin
            report_failure("writeback went back to reset status after the first retirement");
          end
          reset_cycles++;
          compare_field("trace_o.we", 32'(trace_i.we), 32'd0);
          compare_field("halt_o", 32'(halt_i), 32'd0);
        end
        pipe_pkg::cycle_taken_branch: begin
          bubble_cycles++;
          compare_field("trace_o.we", 32'(trace_i.we), 32'd0);
          compare_field("halt_o", 32'(halt_i), 32'd0);
        end
        pipe_pkg::cycle_no_stall: check_retirement();
        default: report_failure("writeback status is not reset, no_stall or taken_branch");
      endcase
    end
  end

endmodule

/* bench/tb_rv_pipeline.sv */
`timescale 1ns/10ps

module tb_rv_pipeline;

  localparam logic [31:0] start_pc    = 32'h0000_0000;
  localparam int          prog_len    = 42;
  localparam int          cycle_limit = 30 + 6 * prog_len;
  localparam logic [31:0] nop_word    = 32'h0000_0013;

  // major opcodes the program needs besides branches and jal
  localparam int opc_imm   = 'h13;
  localparam int opc_lui   = 'h37;
  localparam int opc_auipc = 'h17;
  localparam int opc_jalr  = 'h67;

  logic             clk = 1'b0;
  logic             rst;
  logic [31:0]      pc;
  logic [31:0]      insn = nop_word;
  pipe_pkg::trace_t trace;
  logic             halt;
  logic [31:0]      program_mem [0:63];
  int               cycle_count;
  logic             done;
  int               error_count;
  int               check_count;
  int               retire_count;
  int               total_errors;

  always #4 clk = ~clk;

  function automatic logic [31:0] r_format(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_format(input int imm, input int rs1, input int f3,
                                           input int rd, input int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] u_format(input int imm, input int rd, input int opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] b_format(input int off, input int rs1, input int rs2,
                                           input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_format(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  // word at a fetch address, nop past the end of the program
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr < 32'(4 * prog_len)) begin
      return program_mem[addr[7:2]];
    end
    return nop_word;
  endfunction

  task automatic load_program();
    // upper immediates and forwarding at distance 1, 2 and 3
    program_mem[0]  = u_format('h12345, 1, opc_lui);
    program_mem[1]  = i_format('h678, 1, 0, 1, opc_imm);
    program_mem[2]  = u_format(1, 2, opc_auipc);
    program_mem[3]  = i_format(-5, 0, 0, 3, opc_imm);
    program_mem[4]  = r_format('h20, 3, 1, 0, 4);
    program_mem[5]  = i_format('h401, 3, 5, 5, opc_imm);
    program_mem[6]  = r_format(0, 1, 3, 2, 6);
    program_mem[7]  = r_format(0, 1, 3, 3, 7);
    // write to x0, then read x0 while that write is in memory
    program_mem[8]  = i_format(7, 0, 0, 0, opc_imm);
    program_mem[9]  = r_format(0, 4, 0, 0, 8);
    // register-register ALU
    program_mem[10] = r_format('h20, 6, 3, 5, 9);
    program_mem[11] = r_format(0, 6, 3, 5, 10);
    program_mem[12] = r_format(0, 6, 1, 1, 11);
    program_mem[13] = r_format(0, 2, 1, 4, 12);
    program_mem[14] = r_format(0, 3, 1, 6, 13);
    program_mem[15] = r_format(0, 3, 4, 7, 14);
    // register-immediate ALU
    program_mem[16] = i_format(5, 3, 2, 15, opc_imm);
    program_mem[17] = i_format(5, 3, 3, 16, opc_imm);
    program_mem[18] = i_format(-1, 1, 4, 17, opc_imm);
    program_mem[19] = i_format('hf0, 2, 6, 18, opc_imm);
    program_mem[20] = i_format('hff, 1, 7, 19, opc_imm);
    program_mem[21] = i_format(31, 6, 1, 20, opc_imm);
    program_mem[22] = i_format(4, 20, 5, 21, opc_imm);
    program_mem[23] = i_format('h404, 20, 5, 22, opc_imm);
    // branches and jumps, the odd immediates sit in slots that must be flushed
    program_mem[24] = b_format(8, 6, 15, 1);
    program_mem[25] = i_format(1, 0, 0, 23, opc_imm);
    program_mem[26] = b_format(8, 3, 6, 4);
    program_mem[27] = i_format(99, 0, 0, 23, opc_imm);
    program_mem[28] = b_format(8, 3, 6, 6);
    program_mem[29] = j_format(12, 24);
    program_mem[30] = i_format(55, 0, 0, 23, opc_imm);
    program_mem[31] = i_format(56, 0, 0, 23, opc_imm);
    program_mem[32] = i_format(17, 24, 0, 25, opc_jalr);
    program_mem[33] = i_format(77, 0, 0, 23, opc_imm);
    program_mem[34] = b_format(8, 3, 6, 7);
    program_mem[35] = i_format(33, 0, 0, 23, opc_imm);
    program_mem[36] = b_format(8, 6, 3, 5);
    program_mem[37] = i_format(44, 0, 0, 23, opc_imm);
    program_mem[38] = b_format(8, 23, 6, 0);
    program_mem[39] = i_format(66, 0, 0, 23, opc_imm);
    // fence then ecall
    program_mem[40] = 32'h0ff0_000f;
    program_mem[41] = 32'h0000_0073;
  endtask

  rv_pipeline #(
    .reset_pc(start_pc)
  ) u_rv_pipeline (
    .clk(clk), .rst(rst), .pc_o(pc), .insn_i(insn), .trace_o(trace), .halt_o(halt)
  );

  wb_checker u_wb_checker (
    .clk(clk), .rst(rst), .trace_i(trace), .halt_i(halt), .program_i(program_mem),
    .done_o(done), .error_count_o(error_count), .check_count_o(check_count),
    .retire_count_o(retire_count)
  );

  always @(posedge clk) begin
    if (rst) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  // combinational instruction memory, answered on the falling edge
  always @(negedge clk) begin
    insn <= fetch_word(pc);
  end

  initial begin
    rst  = 1'b1;
    load_program();
    repeat (10) @(negedge clk);
    rst = 1'b0;
    while (!done && cycle_count < cycle_limit) begin
      @(negedge clk);
    end
    total_errors = error_count;
    if (!done) begin
      $display("timeout: no ecall retired within %0d cycles", cycle_limit);
      total_errors = total_errors + 1;
    end
    $display("checks %0d, errors %0d, retired %0d", check_count, total_errors, retire_count);
    if (done && total_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
hw/rv_isa_pkg.sv
hw/pipe_pkg.sv
hw/insn_decoder.sv
hw/reg_file.sv
hw/stage_reg.sv
hw/execute_unit.sv
hw/rv_pipeline.sv
bench/wb_checker.sv
bench/tb_rv_pipeline.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_rv_pipeline -Mdir obj_dir
./obj_dir/Vtb_rv_pipeline > sim.log 2>&1
cat sim.log
if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
